//--- verilog/ddrc_pkg.sv
// Shared widths, command word layout and typedefs for the DDR3 command sequencer.
// Imported by every RTL module and by the testbench to build command words.
// A command word carries DDR3 pins plus buffer strobes; a NOP word carries
// the pause length and the done flag in its address field.
package ddrc_pkg;

    // command memory geometry
    localparam int CMD_WORD_BITS = 32;                   // one command word
    localparam int CMD_ADDR_BITS = 10;                   // 1K words per bank
    localparam int CMD_MEM_DEPTH = 1 << CMD_ADDR_BITS;
    localparam int RUN_BANK_BIT  = CMD_ADDR_BITS;        // run_addr msb picks bank 1

    // DDR3 side
    localparam int ADDRESS_NUMBER = 15;                  // row/column address lines
    localparam int BANK_BITS      = 3;

    // channel buffer side
    localparam int CHN_BITS        = 4;
    localparam int CHN_COUNT       = 1 << CHN_BITS;     // one-hot select width
    localparam int PAGE_BITS       = 2;                 // 4 pages per channel
    localparam int BUF_PAGE_WORDS  = 128;
    localparam int BUF_OFFSET_BITS = $clog2(BUF_PAGE_WORDS);
    localparam int BUF_ADDR_BITS   = PAGE_BITS + BUF_OFFSET_BITS;

    // NOP payload in the address field
    localparam int CMD_PAUSE_BITS = 6;                   // extra NOP cycles
    localparam int CMD_DONE_BIT   = 6;                   // ends the sequence

    // command word field positions, ras/cas/we active high here
    localparam int F_ADDR_LSB = 0;
    localparam int F_BA_LSB   = 15;
    localparam int F_RAS      = 18;
    localparam int F_CAS      = 19;
    localparam int F_WE       = 20;
    localparam int F_ODT      = 21;
    localparam int F_CKE      = 22;
    localparam int F_BUF_WR   = 23;                      // write buffer strobe
    localparam int F_BUF_RD   = 24;                      // read buffer strobe
    // bits 25..31 reserved

    typedef logic [CMD_WORD_BITS-1:0]   cmd_word_t;
    typedef logic [CMD_ADDR_BITS-1:0]   cmd_addr_t;
    typedef logic [CMD_ADDR_BITS:0]     run_addr_t;      // bank bit on top
    typedef logic [ADDRESS_NUMBER-1:0]  sd_addr_t;
    typedef logic [BANK_BITS-1:0]       sd_bank_t;
    typedef logic [CHN_BITS-1:0]        chn_t;
    typedef logic [CHN_COUNT-1:0]       chn_onehot_t;
    typedef logic [PAGE_BITS-1:0]       page_t;
    typedef logic [BUF_ADDR_BITS-1:0]   buf_addr_t;      // page + offset
    typedef logic [CMD_PAUSE_BITS-1:0]  pause_t;

endpackage

//--- verilog/cmd_mem.sv
// Command sequence memory, 1K x 32, single clock.
// Written by software through the top-level write port, read by the sequencer.
// The read register loads only on ren, so a word waits here during NOP pauses.
module cmd_mem
    import ddrc_pkg::*;
(
    input  logic      mclk,
    input  logic      we,      // write strobe for this bank
    input  cmd_addr_t waddr,
    input  cmd_word_t wdata,
    input  logic      ren,     // fetch next word
    input  cmd_addr_t raddr,
    output cmd_word_t rdata    // registered word
);

    cmd_word_t mem [CMD_MEM_DEPTH];

    // write side
    always_ff @(posedge mclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read side, holds its word while ren is low
    always_ff @(posedge mclk) begin
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- verilog/cmd_sequencer.sv
// Run control for the command memories.
// Latches bank and start address on an accepted run_seq, walks the program,
// stretches NOP words by their pause length and ends the run on a done NOP.
// cmd_valid marks the first cycle a fetched word sits at the memory output.
module cmd_sequencer
    import ddrc_pkg::*;
(
    input  logic      mclk,
    input  logic      rst,
    input  run_addr_t run_addr,
    input  logic      run_seq,
    input  logic      cmd_nop,     // from decoder, valid with cmd_valid
    input  logic      seq_done,
    input  pause_t    pause_len,
    output cmd_addr_t rd_addr,
    output logic      ren0,        // bank 0 read enable
    output logic      ren1,        // bank 1 read enable
    output logic      bank_sel,    // 1 - auto bank
    output logic      cmd_valid,
    output logic      run_busy,
    output logic      run_done
);

    pause_t pause_cntr;            // remaining pause cycles after the first
    logic   start;
    logic   done_hit;
    logic   nop_pause;
    logic   pause;
    logic   fetch;

    assign start     = run_seq && !run_busy;                    // run_seq ignored while busy
    assign done_hit  = cmd_valid && cmd_nop && seq_done;        // pause of done word ignored
    assign nop_pause = cmd_valid && cmd_nop && !seq_done && (pause_len != '0);
    assign pause     = nop_pause || (pause_cntr != '0);
    assign fetch     = run_busy && !pause && !done_hit;         // no fetch past done

    assign ren0 = fetch && !bank_sel;
    assign ren1 = fetch && bank_sel;

    // busy, address and bank
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            run_busy <= 1'b0;
            rd_addr  <= '0;
            bank_sel <= 1'b0;
        end else if (start) begin
            run_busy <= 1'b1;
            rd_addr  <= run_addr[CMD_ADDR_BITS-1:0];
            bank_sel <= run_addr[RUN_BANK_BIT];
        end else if (done_hit) begin
            run_busy <= 1'b0;                       // falls as run_done rises
        end else if (fetch) begin
            rd_addr  <= rd_addr + 1'b1;             // next word
        end
    end

    // valid word tracking and done pulse
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmd_valid <= 1'b0;
            run_done  <= 1'b0;
        end else begin
            cmd_valid <= fetch;                     // word lands at edge after ren
            run_done  <= done_hit;                  // lines up with done NOP on pins
        end
    end

    // pause counter
    // first pause cycle is covered by nop_pause, the counter holds the rest
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pause_cntr <= '0;
        end else if (start || done_hit) begin
            pause_cntr <= '0;
        end else if (nop_pause) begin
            pause_cntr <= pause_len - 1'b1;
        end else if (pause_cntr != '0) begin
            pause_cntr <= pause_cntr - 1'b1;
        end
    end

endmodule

//--- verilog/cmd_decode.sv
// Command word decoder and DDR3 pin register.
// NOP, pause length and done flag are decoded combinationally for the sequencer.
// Pins are registered with ras/cas/we turned active low; a NOP is driven while
// cmd_valid is low, cke and odt hold their last value between valid words.
module cmd_decode
    import ddrc_pkg::*;
(
    input  logic      mclk,
    input  logic      rst,
    input  cmd_word_t cmd_word,
    input  logic      cmd_valid,
    output logic      cmd_nop,
    output pause_t    pause_len,
    output logic      seq_done,
    output sd_addr_t  sd_addr,
    output sd_bank_t  sd_ba,
    output logic      sd_ras_n,
    output logic      sd_cas_n,
    output logic      sd_we_n,
    output logic      sd_cke,
    output logic      sd_odt,
    output logic      buf_wr,
    output logic      buf_rd
);

    logic ras;
    logic cas;
    logic we;

    assign ras = cmd_word[F_RAS];
    assign cas = cmd_word[F_CAS];
    assign we  = cmd_word[F_WE];

    assign cmd_nop   = !(ras || cas || we);                        // no command bits set
    assign pause_len = cmd_word[F_ADDR_LSB +: CMD_PAUSE_BITS];
    assign seq_done  = cmd_nop && cmd_word[F_ADDR_LSB + CMD_DONE_BIT];  // only on NOP

    // pin register
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            sd_addr  <= '0;
            sd_ba    <= '0;
            sd_ras_n <= 1'b1;                           // NOP on pins
            sd_cas_n <= 1'b1;
            sd_we_n  <= 1'b1;
            sd_cke   <= 1'b0;
            sd_odt   <= 1'b0;
            buf_wr   <= 1'b0;
            buf_rd   <= 1'b0;
        end else if (cmd_valid) begin
            sd_addr  <= cmd_word[F_ADDR_LSB +: ADDRESS_NUMBER];
            sd_ba    <= cmd_word[F_BA_LSB +: BANK_BITS];
            sd_ras_n <= !ras;
            sd_cas_n <= !cas;
            sd_we_n  <= !we;
            sd_cke   <= cmd_word[F_CKE];                // NOP words may change cke too
            sd_odt   <= cmd_word[F_ODT];
            buf_wr   <= cmd_word[F_BUF_WR] && !cmd_nop; // strobes only with a command
            buf_rd   <= cmd_word[F_BUF_RD] && !cmd_nop;
        end else begin
            sd_ras_n <= 1'b1;                           // idle or paused
            sd_cas_n <= 1'b1;
            sd_we_n  <= 1'b1;
            buf_wr   <= 1'b0;
            buf_rd   <= 1'b0;
        end
    end

endmodule

//--- verilog/buf_addr_gen.sv
// Channel buffer address generator.
// On an accepted run picks the channel's internal page, sets the one-hot
// channel select and starts the address at the page base. Each buffer
// strobe then moves the address on by one word.
module buf_addr_gen
    import ddrc_pkg::*;
(
    input  logic        mclk,
    input  logic        rst,
    input  logic        run_seq,
    input  logic        run_busy,
    input  chn_t        run_chn,
    input  page_t       port0_int_page,
    input  page_t       port1_int_page,
    input  logic        buf_wr,
    input  logic        buf_rd,
    output buf_addr_t   buf_addr,
    output chn_onehot_t buf_sel
);

    page_t run_page;
    logic  start;

    assign start = run_seq && !run_busy;    // same acceptance as sequencer

    // page source per channel
    always_comb begin
        case (run_chn)
            chn_t'(0): run_page = port0_int_page;
            chn_t'(1): run_page = port1_int_page;
            default:   run_page = '0;       // no page source yet
        endcase
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            buf_addr <= '0;
            buf_sel  <= '0;
        end else if (start) begin
            buf_addr <= {run_page, {BUF_OFFSET_BITS{1'b0}}};  // page * BUF_PAGE_WORDS
            buf_sel  <= chn_onehot_t'(1) << run_chn;
        end else if (buf_wr || buf_rd) begin
            buf_addr <= buf_addr + 1'b1;    // one word per strobe
        end
    end

endmodule

//--- verilog/ddrc_sequencer.sv
// Top level of the DDR3 command sequencer.
// Two command memories (bank 0 manual, bank 1 auto) feed the run control and
// the pin decoder; the buffer address generator follows the buffer strobes.
// Holds only the write enable split and the bank word multiplexer.
module ddrc_sequencer
    import ddrc_pkg::*;
(
    input  logic        mclk,
    input  logic        rst,
    // command memory write
    input  logic        cmd_we,
    input  logic        cmd_bank,        // 0 - manual, 1 - auto
    input  cmd_addr_t   cmd_waddr,
    input  cmd_word_t   cmd_wdata,
    // run interface
    input  run_addr_t   run_addr,
    input  chn_t        run_chn,
    input  logic        run_seq,
    output logic        run_busy,
    output logic        run_done,
    // channel pages
    input  page_t       port0_int_page,
    input  page_t       port1_int_page,
    // DDR3 command pins
    output sd_addr_t    sd_addr,
    output sd_bank_t    sd_ba,
    output logic        sd_ras_n,
    output logic        sd_cas_n,
    output logic        sd_we_n,
    output logic        sd_cke,
    output logic        sd_odt,
    // channel buffer
    output logic        buf_wr,
    output logic        buf_rd,
    output buf_addr_t   buf_addr,
    output chn_onehot_t buf_sel
);

    cmd_addr_t rd_addr;
    cmd_word_t cmd0_word;
    cmd_word_t cmd1_word;
    cmd_word_t cmd_word;
    logic      we0;
    logic      we1;
    logic      ren0;
    logic      ren1;
    logic      bank_sel;
    logic      cmd_valid;
    logic      cmd_nop;
    logic      seq_done;
    pause_t    pause_len;

    assign we0      = cmd_we && !cmd_bank;
    assign we1      = cmd_we && cmd_bank;
    assign cmd_word = bank_sel ? cmd1_word : cmd0_word;   // active bank word

    cmd_mem cmd_mem_0_i (
        .mclk  (mclk),
        .we    (we0),
        .waddr (cmd_waddr),
        .wdata (cmd_wdata),
        .ren   (ren0),
        .raddr (rd_addr),
        .rdata (cmd0_word)
    );

    cmd_mem cmd_mem_1_i (
        .mclk  (mclk),
        .we    (we1),
        .waddr (cmd_waddr),
        .wdata (cmd_wdata),
        .ren   (ren1),
        .raddr (rd_addr),
        .rdata (cmd1_word)
    );

    cmd_sequencer cmd_sequencer_i (
        .mclk      (mclk),
        .rst       (rst),
        .run_addr  (run_addr),
        .run_seq   (run_seq),
        .cmd_nop   (cmd_nop),
        .seq_done  (seq_done),
        .pause_len (pause_len),
        .rd_addr   (rd_addr),
        .ren0      (ren0),
        .ren1      (ren1),
        .bank_sel  (bank_sel),
        .cmd_valid (cmd_valid),
        .run_busy  (run_busy),
        .run_done  (run_done)
    );

    cmd_decode cmd_decode_i (
        .mclk      (mclk),
        .rst       (rst),
        .cmd_word  (cmd_word),
        .cmd_valid (cmd_valid),
        .cmd_nop   (cmd_nop),
        .pause_len (pause_len),
        .seq_done  (seq_done),
        .sd_addr   (sd_addr),
        .sd_ba     (sd_ba),
        .sd_ras_n  (sd_ras_n),
        .sd_cas_n  (sd_cas_n),
        .sd_we_n   (sd_we_n),
        .sd_cke    (sd_cke),
        .sd_odt    (sd_odt),
        .buf_wr    (buf_wr),
        .buf_rd    (buf_rd)
    );

    buf_addr_gen buf_addr_gen_i (
        .mclk           (mclk),
        .rst            (rst),
        .run_seq        (run_seq),
        .run_busy       (run_busy),
        .run_chn        (run_chn),
        .port0_int_page (port0_int_page),
        .port1_int_page (port1_int_page),
        .buf_wr         (buf_wr),
        .buf_rd         (buf_rd),
        .buf_addr       (buf_addr),
        .buf_sel        (buf_sel)
    );

endmodule

//--- testbench/ddrc_sequencer_checker.sv
// Protocol assertions on the sequencer top-level ports.
// Bound into every ddrc_sequencer instance; reports through $error only.
module ddrc_sequencer_checker (
    input logic mclk,
    input logic rst,
    input logic run_busy,
    input logic run_done,
    input logic sd_ras_n,
    input logic sd_cas_n,
    input logic sd_we_n,
    input logic buf_wr,
    input logic buf_rd
);

    int fail_count;                    // assertion failures so far

    // run_done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge mclk) disable iff (rst)
        run_done |=> !run_done)
        else begin
            $error("run_done stayed high for more than one cycle");
            fail_count++;
        end

    // idle pins carry a NOP and no buffer strobe
    a_idle_quiet: assert property (@(posedge mclk) disable iff (rst)
        !run_busy |-> (sd_ras_n && sd_cas_n && sd_we_n && !buf_wr && !buf_rd))
        else begin
            $error("command or buffer strobe while the sequencer is idle");
            fail_count++;
        end

    // busy ends only through a done NOP
    a_busy_fall: assert property (@(posedge mclk) disable iff (rst)
        $fell(run_busy) |-> run_done)
        else begin
            $error("run_busy fell without run_done");
            fail_count++;
        end

    a_done_fall: assert property (@(posedge mclk) disable iff (rst)
        run_done |-> $fell(run_busy))
        else begin
            $error("run_done without run_busy falling at the same edge");
            fail_count++;
        end

endmodule

bind ddrc_sequencer ddrc_sequencer_checker ddrc_sequencer_checker_i (
    .mclk     (mclk),
    .rst      (rst),
    .run_busy (run_busy),
    .run_done (run_done),
    .sd_ras_n (sd_ras_n),
    .sd_cas_n (sd_cas_n),
    .sd_we_n  (sd_we_n),
    .buf_wr   (buf_wr),
    .buf_rd   (buf_rd)
);

//--- testbench/tb_ddrc_sequencer.sv
// Table-driven testbench for the DDR3 command sequencer.
// Loads command programs into both banks through the write port, then runs
// each table row and compares pins, run status and buffer address cycle by
// cycle with a model that walks a shadow copy of the command memories.
module tb_ddrc_sequencer
    import ddrc_pkg::*;
();

    localparam int DRIVE_DLY   = 10;     // input drive after rising edge
    localparam int RUN_TIMEOUT = 200;    // cycles allowed per run
    localparam int SEED        = 65;
    localparam int N_TESTS     = 8;

    typedef struct {
        string     name;
        logic      bank;
        cmd_addr_t start;
        chn_t      chn;
        page_t     page0;
        page_t     page1;
        int        cmds;                 // non-NOP words expected on pins
        buf_addr_t final_addr;
        logic      mid_pulse;            // extra run_seq while busy
    } test_row_t;

    logic        mclk;
    logic        rst;
    logic        cmd_we;
    logic        cmd_bank;
    cmd_addr_t   cmd_waddr;
    cmd_word_t   cmd_wdata;
    run_addr_t   run_addr;
    chn_t        run_chn;
    logic        run_seq;
    page_t       port0_int_page;
    page_t       port1_int_page;
    logic        run_busy;
    logic        run_done;
    sd_addr_t    sd_addr;
    sd_bank_t    sd_ba;
    logic        sd_ras_n;
    logic        sd_cas_n;
    logic        sd_we_n;
    logic        sd_cke;
    logic        sd_odt;
    logic        buf_wr;
    logic        buf_rd;
    buf_addr_t   buf_addr;
    chn_onehot_t buf_sel;
    logic [25:0] pins;                   // compared bundle, run_done in bit 0

    test_row_t   rows [N_TESTS];
    cmd_word_t   shadow [2][CMD_MEM_DEPTH];
    logic [25:0] exp_pins [$];
    buf_addr_t   exp_baddr [$];
    int          exp_cmds;
    int          errors;
    int          test_errs;
    int          tests_failed;
    bit          aborted;

    assign pins = {sd_addr, sd_ba, sd_ras_n, sd_cas_n, sd_we_n, sd_cke, sd_odt,
                   buf_wr, buf_rd, run_done};

    ddrc_sequencer ddrc_sequencer_i (.*);

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;
    end

    task automatic report_value(input string test, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
        $display("** Error: %s %s expected %h actual %h", test, what, exp, act);
        test_errs++;
    endtask

    task automatic report_fault(input string test, input string msg);
        $display("%s: %s", test, msg);
        test_errs++;
    endtask

    task automatic write_word(input logic bank, input cmd_addr_t addr, input cmd_word_t w);
        @(posedge mclk);
        #DRIVE_DLY;
        cmd_we    = 1'b1;
        cmd_bank  = bank;
        cmd_waddr = addr;
        cmd_wdata = w;
        shadow[bank][addr] = w;
        @(posedge mclk);
        #DRIVE_DLY;
        cmd_we = 1'b0;
    endtask

    task automatic put_cmd(input logic bank, input cmd_addr_t addr);
        cmd_word_t   w;
        logic [31:0] rnd;
        w   = '0;
        rnd = $urandom;
        w[F_ADDR_LSB +: ADDRESS_NUMBER] = rnd[ADDRESS_NUMBER-1:0];
        w[F_BA_LSB +: BANK_BITS]        = rnd[ADDRESS_NUMBER +: BANK_BITS];
        w[F_ODT] = rnd[20];
        w[F_CKE] = 1'b1;
        rnd = $urandom_range(1, 7);          // at least one of ras/cas/we
        w[F_RAS] = rnd[0];
        w[F_CAS] = rnd[1];
        w[F_WE]  = rnd[2];
        rnd = $urandom_range(1, 3);          // wr, rd or both
        w[F_BUF_WR] = rnd[0];
        w[F_BUF_RD] = rnd[1];
        write_word(bank, addr, w);
    endtask

    task automatic put_nop(input logic bank, input cmd_addr_t addr,
                           input pause_t pause, input logic done);
        cmd_word_t w;
        w = '0;
        w[F_ADDR_LSB +: CMD_PAUSE_BITS]     = pause;
        w[F_ADDR_LSB + CMD_DONE_BIT]        = done;
        w[F_CKE]                            = 1'b1;
        w[F_BUF_WR]                         = 1'b1;   // no strobe from a NOP
        w[F_BUF_RD]                         = 1'b1;
        write_word(bank, addr, w);
    endtask

    task automatic load_programs();
        int i;
        for (i = 0; i < 4; i++) begin
            put_cmd(1'b0, cmd_addr_t'(i));   // back to back
        end
        put_nop(1'b0, 10'd4, 6'd0, 1'b1);
        put_cmd(1'b0, 10'd5);                // behind done, never runs
        put_cmd(1'b0, 10'd16);
        put_nop(1'b0, 10'd17, 6'd0, 1'b0);
        put_cmd(1'b0, 10'd18);
        put_nop(1'b0, 10'd19, 6'd1, 1'b0);
        put_cmd(1'b0, 10'd20);
        put_nop(1'b0, 10'd21, 6'd63, 1'b0);
        put_cmd(1'b0, 10'd22);
        put_nop(1'b0, 10'd23, 6'd5, 1'b1);   // pause ignored on done
        put_cmd(1'b0, 10'd24);
        put_cmd(1'b0, 10'd64);
        put_cmd(1'b0, 10'd65);
        put_nop(1'b0, 10'd66, 6'd0, 1'b1);
        put_cmd(1'b0, 10'd67);
        for (i = 64; i < 69; i++) begin
            put_cmd(1'b1, cmd_addr_t'(i));   // same offsets, other bank
        end
        put_nop(1'b1, 10'd69, 6'd2, 1'b0);
        put_cmd(1'b1, 10'd70);
        put_nop(1'b1, 10'd71, 6'd0, 1'b1);
        put_cmd(1'b1, 10'd72);
        for (i = 128; i < 131; i++) begin
            put_cmd(1'b1, cmd_addr_t'(i));
        end
        put_nop(1'b1, 10'd131, 6'd0, 1'b1);
        put_cmd(1'b1, 10'd132);
    endtask

    task automatic fill_table();
        rows[0] = '{"bank0_b2b",      1'b0, 10'd0,   4'd0,  2'd2, 2'd1, 4, 9'd260, 1'b0};
        rows[1] = '{"nop_pause",      1'b0, 10'd16,  4'd1,  2'd0, 2'd3, 4, 9'd388, 1'b0};
        rows[2] = '{"bank0_same_off", 1'b0, 10'd64,  4'd2,  2'd1, 2'd1, 2, 9'd2,   1'b0};
        rows[3] = '{"bank1_same_off", 1'b1, 10'd64,  4'd5,  2'd1, 2'd2, 6, 9'd6,   1'b0};
        rows[4] = '{"chn0_page",      1'b1, 10'd128, 4'd0,  2'd3, 2'd0, 3, 9'd387, 1'b0};
        rows[5] = '{"chn1_page",      1'b1, 10'd128, 4'd1,  2'd0, 2'd2, 3, 9'd259, 1'b0};
        rows[6] = '{"chn15_page0",    1'b1, 10'd128, 4'd15, 2'd3, 2'd3, 3, 9'd3,   1'b0};
        rows[7] = '{"busy_rerun",     1'b0, 10'd16,  4'd0,  2'd1, 2'd0, 4, 9'd132, 1'b1};
    endtask

    // walk the shadow memory and list the pins for every cycle of the run
    task automatic build_stream(input logic bank, input cmd_addr_t start, input buf_addr_t base);
        cmd_word_t   w;
        cmd_addr_t   a;
        logic        nop;
        logic [25:0] p;
        buf_addr_t   cnt;
        int          guard;
        bit          stop;
        exp_pins.delete();
        exp_baddr.delete();
        exp_cmds = 0;
        a        = start;
        cnt      = base;
        guard    = 0;
        stop     = 1'b0;
        while (!stop && guard < CMD_MEM_DEPTH) begin
            w   = shadow[bank][a];
            nop = !(w[F_RAS] || w[F_CAS] || w[F_WE]);
            p   = {w[F_ADDR_LSB +: ADDRESS_NUMBER], w[F_BA_LSB +: BANK_BITS],
                   !w[F_RAS], !w[F_CAS], !w[F_WE], w[F_CKE], w[F_ODT],
                   w[F_BUF_WR] && !nop, w[F_BUF_RD] && !nop, 1'b0};
            if (nop && w[F_ADDR_LSB + CMD_DONE_BIT]) begin
                p[0] = 1'b1;                 // run_done with the done NOP
                exp_pins.push_back(p);
                exp_baddr.push_back(cnt);
                stop = 1'b1;
            end else if (nop) begin
                repeat (int'(w[F_ADDR_LSB +: CMD_PAUSE_BITS]) + 1) begin
                    exp_pins.push_back(p);
                    exp_baddr.push_back(cnt);
                end
            end else begin
                exp_pins.push_back(p);
                exp_baddr.push_back(cnt);
                exp_cmds++;
                if (p[2] || p[1]) cnt++;     // address moves after the strobe
            end
            a++;
            guard++;
        end
    endtask

    task automatic check_reset();
        test_errs = 0;
        assert (run_busy === 1'b0 && run_done === 1'b0)
            else report_fault("reset_values", "run status not low after reset");
        assert (sd_ras_n === 1'b1 && sd_cas_n === 1'b1 && sd_we_n === 1'b1)
            else report_fault("reset_values", "command pins do not show a NOP after reset");
        assert (sd_cke === 1'b0 && buf_wr === 1'b0 && buf_rd === 1'b0)
            else report_fault("reset_values", "cke or buffer strobes not low after reset");
        assert (buf_sel === '0) else report_value("reset_values", "buf_sel", 0, buf_sel);
    endtask

    task automatic run_row(input test_row_t row);
        buf_addr_t   base;
        chn_onehot_t sel;
        int          idx;
        int          cmd_seen;
        bit          seen_done;
        test_errs = 0;
        base = (row.chn == 0) ? {row.page0, 7'd0} :
               (row.chn == 1) ? {row.page1, 7'd0} : '0;
        sel  = '0;
        sel[row.chn] = 1'b1;                 // one bit per channel
        build_stream(row.bank, row.start, base);
        @(posedge mclk);
        #DRIVE_DLY;
        run_addr       = {row.bank, row.start};
        run_chn        = row.chn;
        port0_int_page = row.page0;
        port1_int_page = row.page1;
        run_seq        = 1'b1;
        @(posedge mclk);                     // edge 0, run accepted
        #DRIVE_DLY;
        run_seq = 1'b0;
        assert (run_busy === 1'b1) else report_fault(row.name, "run_busy did not rise");
        assert (buf_sel === sel) else report_value(row.name, "buf_sel", sel, buf_sel);
        assert (buf_addr === base) else report_value(row.name, "buf_addr", base, buf_addr);
        @(posedge mclk);                     // edge 1, word still in memory
        #DRIVE_DLY;
        assert (sd_ras_n && sd_cas_n && sd_we_n && !buf_wr && !buf_rd)
            else report_fault(row.name, "command reached the pins before edge 2");
        idx       = 0;
        cmd_seen  = 0;
        seen_done = 1'b0;
        while (!seen_done && idx < RUN_TIMEOUT) begin
            @(posedge mclk);
            #DRIVE_DLY;
            if (row.mid_pulse && idx == 3) begin
                run_addr = {1'b1, 10'd128};  // other program, must be ignored
                run_chn  = 4'd2;
                run_seq  = 1'b1;
            end else begin
                run_seq = 1'b0;
            end
            assert (idx < exp_pins.size())
                else report_fault(row.name, "pins go on past the end of the program");
            if (idx < exp_pins.size()) begin
                assert (pins === exp_pins[idx])
                    else report_value(row.name, "pins", exp_pins[idx], pins);
                assert (buf_addr === exp_baddr[idx])
                    else report_value(row.name, "buf_addr", exp_baddr[idx], buf_addr);
                assert (run_busy === !exp_pins[idx][0])
                    else report_value(row.name, "run_busy", !exp_pins[idx][0], run_busy);
            end
            if (!sd_ras_n || !sd_cas_n || !sd_we_n) cmd_seen++;
            seen_done = run_done;
            idx++;
        end
        if (!seen_done) begin
            report_fault(row.name, "timed out waiting for run_done");
            aborted = 1'b1;
        end
        assert (idx == exp_pins.size())
            else report_value(row.name, "run length", exp_pins.size(), idx);
        assert (exp_cmds == row.cmds)
            else report_value(row.name, "program commands", row.cmds, exp_cmds);
        assert (cmd_seen == row.cmds)
            else report_value(row.name, "pin commands", row.cmds, cmd_seen);
        @(posedge mclk);
        #DRIVE_DLY;
        assert (run_busy === 1'b0 && run_done === 1'b0)
            else report_fault(row.name, "run status not idle after the done cycle");
        assert (sd_ras_n && sd_cas_n && sd_we_n && !buf_wr && !buf_rd)
            else report_fault(row.name, "a word behind the done NOP reached the pins");
        assert (buf_addr === row.final_addr)
            else report_value(row.name, "final buf_addr", row.final_addr, buf_addr);
        assert (buf_sel === sel) else report_value(row.name, "final buf_sel", sel, buf_sel);
    endtask

    task automatic log_test(input string name);
        $display("test %-16s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "bad", test_errs);
        errors += test_errs;
        if (test_errs != 0) tests_failed++;
    endtask

    initial begin
        int t;
        void'($urandom(SEED));
        errors         = 0;
        tests_failed   = 0;
        aborted        = 1'b0;
        rst            = 1'b1;
        cmd_we         = 1'b0;
        cmd_bank       = 1'b0;
        cmd_waddr      = '0;
        cmd_wdata      = '0;
        run_addr       = '0;
        run_chn        = '0;
        run_seq        = 1'b0;
        port0_int_page = '0;
        port1_int_page = '0;
        repeat (5) @(posedge mclk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_reset();
        log_test("reset_values");
        load_programs();
        fill_table();
        for (t = 0; t < N_TESTS && !aborted; t++) begin
            run_row(rows[t]);
            log_test(rows[t].name);
        end
        errors += ddrc_sequencer_i.ddrc_sequencer_checker_i.fail_count;   // bound assertions
        $display("tests run: %0d, failed: %0d, errors: %0d", t + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/ddrc_pkg.sv
verilog/cmd_mem.sv
verilog/cmd_sequencer.sv
verilog/cmd_decode.sv
verilog/buf_addr_gen.sv
verilog/ddrc_sequencer.sv
testbench/ddrc_sequencer_checker.sv
testbench/tb_ddrc_sequencer.sv

//--- Bender.yml
package:
  name: ddrc_sequencer

sources:
  - files:
      - verilog/ddrc_pkg.sv
      - verilog/cmd_mem.sv
      - verilog/cmd_sequencer.sv
      - verilog/cmd_decode.sv
      - verilog/buf_addr_gen.sv
      - verilog/ddrc_sequencer.sv
  - target: test
    files:
      - testbench/ddrc_sequencer_checker.sv
      - testbench/tb_ddrc_sequencer.sv
